// File: src/bp_pkg.sv
package bp_pkg;

    // kind of a control-flow instruction as seen by fetch and execute
    typedef enum logic [1:0] {
        br_none = 2'd0,  // not a branch or a btb miss
        br_jump = 2'd1,  // unconditional jump
        br_call = 2'd2,  // call that pushes pc + 1
        br_ret  = 2'd3   // return with its target from the ras
    } br_kind_e;

endpackage

// File: src/btb.sv
`timescale 1ns/1ps

module btb #(
    parameter addr_width  = 30,
    parameter btb_entries = 16
)(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  advance,
    input  bp_pkg::br_kind_e      kind_ex,
    input  logic [addr_width-1:0] pc_ex,
    input  logic [addr_width-1:0] target_ex,
    input  logic [addr_width-1:0] pc_if,
    output bp_pkg::br_kind_e      kind_pdc,
    output logic [addr_width-1:0] target_pdc
);
    localparam idx_width = $clog2(btb_entries);
    localparam tag_width = addr_width - idx_width;

    logic [btb_entries-1:0] valid;                       // only valid bits are reset
    logic [tag_width-1:0]   tag_mem    [btb_entries];
    bp_pkg::br_kind_e       kind_mem   [btb_entries];
    logic [addr_width-1:0]  target_mem [btb_entries];

    logic [idx_width-1:0] rd_idx;
    logic [tag_width-1:0] rd_tag;
    logic [idx_width-1:0] wr_idx;
    logic [tag_width-1:0] wr_tag;
    logic                 hit;
    logic                 train;

    assign rd_idx = pc_if[idx_width-1:0];
    assign rd_tag = pc_if[addr_width-1:idx_width];
    assign wr_idx = pc_ex[idx_width-1:0];
    assign wr_tag = pc_ex[addr_width-1:idx_width];

    // learn every resolved control-flow instruction
    assign train = advance && (kind_ex != bp_pkg::br_none);

    assign hit = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (train) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (train) begin
            tag_mem[wr_idx]    <= wr_tag;
            kind_mem[wr_idx]   <= kind_ex;
            target_mem[wr_idx] <= target_ex;
        end
    end

    always_comb begin
        kind_pdc   = bp_pkg::br_none;  // miss looks like a plain instruction
        target_pdc = '0;
        if (hit) begin
            kind_pdc   = kind_mem[rd_idx];
            target_pdc = target_mem[rd_idx];
        end
    end

endmodule

// File: src/ras.sv
`timescale 1ns/1ps

module ras #(
    parameter addr_width = 30,
    parameter stack_len  = 16
)(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  advance,
    input  bp_pkg::br_kind_e      kind_ex,
    input  logic [addr_width-1:0] pc_ex,
    input  logic                  mis_pdc,
    input  bp_pkg::br_kind_e      kind_pdc,
    output logic [addr_width-1:0] ret_pc_pdc
);
    typedef enum logic [2:0] {hold, push, replace, pop, pop2, pop3} ras_op_e;

    logic [addr_width-1:0] stk     [stack_len];
    logic [addr_width-1:0] stk_ext [stack_len+3];  // three zero slots below the bottom
    logic [addr_width-1:0] stk_nxt [stack_len];
    logic [addr_width-1:0] ret_pc_ex;
    logic                  is_ret_pdc;
    logic                  is_call_ex;
    logic                  is_ret_ex;
    logic                  fix_flag;               // repair state after a mispredicted return
    logic                  fix_flag_nxt;
    logic [1:0]            pop_cnt;
    ras_op_e               op;

    assign is_ret_pdc = kind_pdc == bp_pkg::br_ret;
    assign is_call_ex = kind_ex == bp_pkg::br_call;
    assign is_ret_ex  = kind_ex == bp_pkg::br_ret;
    assign ret_pc_ex  = pc_ex + addr_width'(1);

    always_comb begin
        op           = hold;
        fix_flag_nxt = fix_flag;
        if (is_call_ex) begin
            op = is_ret_pdc ? replace : push;
        end else if (is_ret_ex && mis_pdc) begin
            fix_flag_nxt = !fix_flag;
            if (!fix_flag) begin
                op = is_ret_pdc ? pop3 : pop2;
            end else begin
                op = is_ret_pdc ? pop : hold;
            end
        end else if (is_ret_ex) begin
            fix_flag_nxt = 1'b0;
            op           = is_ret_pdc ? pop : hold;
        end else if (is_ret_pdc) begin
            op = pop;
        end
    end

    always_comb begin
        case (op)
            pop2:    pop_cnt = 2'd2;
            pop3:    pop_cnt = 2'd3;
            default: pop_cnt = 2'd1;
        endcase
    end

    always_comb begin
        for (int i = 0; i < stack_len; i++) begin
            stk_ext[i] = stk[i];
        end
        for (int i = stack_len; i < stack_len + 3; i++) begin
            stk_ext[i] = '0;
        end
    end

    always_comb begin
        stk_nxt = stk;
        case (op)
            push: begin
                stk_nxt[0] = ret_pc_ex;
                for (int i = 1; i < stack_len; i++) begin
                    stk_nxt[i] = stk[i-1];
                end
            end
            replace: stk_nxt[0] = ret_pc_ex;  // call and return cancel out
            pop, pop2, pop3: begin
                for (int i = 0; i < stack_len; i++) begin
                    stk_nxt[i] = stk_ext[i + int'(pop_cnt)];
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            stk      <= '{default: '0};
            fix_flag <= 1'b0;
        end else if (advance) begin
            stk      <= stk_nxt;
            fix_flag <= fix_flag_nxt;
        end
    end

    always_comb begin
        ret_pc_pdc = '0;
        if (is_ret_pdc) begin
            ret_pc_pdc = is_call_ex ? ret_pc_ex : stk[0];  // bypass the push in flight
        end
    end

endmodule

// File: src/pc_gen.sv
`timescale 1ns/1ps

module pc_gen #(
    parameter                  addr_width = 30,
    parameter [addr_width-1:0] reset_pc   = '0
)(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  advance,
    input  logic                  mis_pdc,
    input  logic [addr_width-1:0] target_ex,
    input  bp_pkg::br_kind_e      kind_pdc,
    input  logic [addr_width-1:0] target_pdc,
    input  logic [addr_width-1:0] ret_pc_pdc,
    output logic [addr_width-1:0] pc_if,
    output logic [addr_width-1:0] pred_pc
);
    logic [addr_width-1:0] seq_pc;
    logic [addr_width-1:0] pc_nxt;

    assign seq_pc = pc_if + addr_width'(1);

    always_comb begin
        case (kind_pdc)
            bp_pkg::br_ret:  pred_pc = ret_pc_pdc;
            bp_pkg::br_jump,
            bp_pkg::br_call: pred_pc = target_pdc;
            default:         pred_pc = seq_pc;  // fall through
        endcase
    end

    // execute redirect wins over the prediction
    assign pc_nxt = mis_pdc ? target_ex : pred_pc;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_if <= reset_pc;
        end else if (advance) begin
            pc_if <= pc_nxt;
        end
    end

endmodule

// File: src/bp_top.sv
`timescale 1ns/1ps

module bp_top #(
    parameter                  addr_width  = 30,
    parameter                  stack_len   = 16,
    parameter                  btb_entries = 16,
    parameter [addr_width-1:0] reset_pc    = 'h100
)(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  advance,
    input  bp_pkg::br_kind_e      kind_ex,
    input  logic [addr_width-1:0] pc_ex,
    input  logic [addr_width-1:0] target_ex,
    input  logic                  mis_pdc,
    output logic [addr_width-1:0] pc_if,
    output logic [addr_width-1:0] pred_pc
);
    bp_pkg::br_kind_e      kind_pdc;
    logic [addr_width-1:0] target_pdc;
    logic [addr_width-1:0] ret_pc_pdc;

    btb #(
        .addr_width  (addr_width),
        .btb_entries (btb_entries)
    ) u_btb (
        .clk        (clk),
        .rstn       (rstn),
        .advance    (advance),
        .kind_ex    (kind_ex),
        .pc_ex      (pc_ex),
        .target_ex  (target_ex),
        .pc_if      (pc_if),
        .kind_pdc   (kind_pdc),
        .target_pdc (target_pdc)
    );

    ras #(
        .addr_width (addr_width),
        .stack_len  (stack_len)
    ) u_ras (
        .clk        (clk),
        .rstn       (rstn),
        .advance    (advance),
        .kind_ex    (kind_ex),
        .pc_ex      (pc_ex),
        .mis_pdc    (mis_pdc),
        .kind_pdc   (kind_pdc),
        .ret_pc_pdc (ret_pc_pdc)
    );

    pc_gen #(
        .addr_width (addr_width),
        .reset_pc   (reset_pc)
    ) u_pc_gen (
        .clk        (clk),
        .rstn       (rstn),
        .advance    (advance),
        .mis_pdc    (mis_pdc),
        .target_ex  (target_ex),
        .kind_pdc   (kind_pdc),
        .target_pdc (target_pdc),
        .ret_pc_pdc (ret_pc_pdc),
        .pc_if      (pc_if),
        .pred_pc    (pred_pc)
    );

endmodule

// File: bench/bp_checker.sv
`timescale 1ns/1ps

module bp_checker #(
    parameter                  addr_width = 30,
    parameter [addr_width-1:0] reset_pc   = '0
)(
    input logic                  clk,
    input logic                  rstn,
    input logic                  advance,
    input logic                  mis_pdc,
    input logic [addr_width-1:0] target_ex,
    input logic [addr_width-1:0] pc_if
);
    int fail_count = 0;  // read by the testbench at the end

    reset_pc_a: assert property (@(posedge clk) !rstn |=> pc_if == reset_pc)
        else begin
            fail_count++;
            $error("pc_if is not reset_pc one cycle after reset");
        end

    hold_a: assert property (@(posedge clk) rstn && !advance |=> $stable(pc_if))
        else begin
            fail_count++;
            $error("pc_if moved while advance was low");
        end

    redirect_a: assert property (@(posedge clk)
            rstn && advance && mis_pdc |=> pc_if == $past(target_ex))
        else begin
            fail_count++;
            $error("pc_if did not follow target_ex after a misprediction");
        end

endmodule

bind bp_top bp_checker #(
    .addr_width (addr_width),
    .reset_pc   (reset_pc)
) u_chk (
    .clk       (clk),
    .rstn      (rstn),
    .advance   (advance),
    .mis_pdc   (mis_pdc),
    .target_ex (target_ex),
    .pc_if     (pc_if)
);

// File: bench/bp_monitor.sv
`timescale 1ns/1ps

module bp_monitor #(
    parameter addr_width = 30
)(
    input  logic                  clk,
    input  logic                  check_en,
    input  logic                  done,
    input  int                    test_id,
    input  logic [addr_width-1:0] exp_pc_if,
    input  logic [addr_width-1:0] exp_pred_pc,
    input  logic [addr_width-1:0] pc_if,
    input  logic [addr_width-1:0] pred_pc,
    output int                    check_count,
    output int                    error_count,
    output int                    tests_run,
    output int                    tests_failed
);
    int n_checks    = 0;
    int n_errors    = 0;
    int n_tests     = 0;
    int n_failed    = 0;
    int cur_test    = 0;
    int test_checks = 0;
    int test_errors = 0;

    assign check_count  = n_checks;
    assign error_count  = n_errors;
    assign tests_run    = n_tests;
    assign tests_failed = n_failed;

    task automatic report_test();
        n_tests++;
        if (test_errors == 0) begin
            $display("test %0d passed, %0d checks", cur_test, test_checks);
        end else begin
            n_failed++;
            $display("test %0d failed, %0d of %0d checks wrong", cur_test, test_errors,
                     test_checks);
        end
    endtask

    task automatic compare(input string name, input logic [addr_width-1:0] got,
                           input logic [addr_width-1:0] exp);
        n_checks++;
        test_checks++;
        if (got !== exp) begin
            n_errors++;
            test_errors++;
            $display("ERROR at %0t: test %0d %s is %h, expected %h", $time, cur_test, name,
                     got, exp);
        end
    endtask

    always @(posedge clk) begin
        #9;  // just before the next edge
        if (check_en) begin
            if (test_id != cur_test) begin
                if (cur_test != 0) begin
                    report_test();
                end
                cur_test    = test_id;
                test_checks = 0;
                test_errors = 0;
            end
            compare("pc_if", pc_if, exp_pc_if);
            compare("pred_pc", pred_pc, exp_pred_pc);
        end else if (done && cur_test != 0) begin
            report_test();
            cur_test = 0;
        end
    end

endmodule

// File: bench/bp_tb.sv
`timescale 1ns/1ps

module bp_tb;
    localparam int addr_width = 30;
    localparam int n_lines    = 40;
    localparam int n_cols     = 8;
    localparam int n_tests    = 6;
    localparam int max_gap    = 2;
    localparam int max_cycles = n_lines * (max_gap + 1) + 20;

    logic                  clk = 1'b0;
    logic                  rstn;
    logic                  advance;
    bp_pkg::br_kind_e      kind_ex;
    logic [addr_width-1:0] pc_ex;
    logic [addr_width-1:0] target_ex;
    logic                  mis_pdc;
    logic [addr_width-1:0] pc_if;
    logic [addr_width-1:0] pred_pc;

    logic                  check_en;
    logic                  done;
    int                    test_id;
    logic [addr_width-1:0] exp_pc_if;
    logic [addr_width-1:0] exp_pred_pc;
    int                    check_count;
    int                    error_count;
    int                    tests_run;
    int                    tests_failed;
    int                    cycles = 0;
    logic [31:0]           stim [n_lines*n_cols];

    always #5 clk = ~clk;

    bp_top UUT (
        .clk       (clk),
        .rstn      (rstn),
        .advance   (advance),
        .kind_ex   (kind_ex),
        .pc_ex     (pc_ex),
        .target_ex (target_ex),
        .mis_pdc   (mis_pdc),
        .pc_if     (pc_if),
        .pred_pc   (pred_pc)
    );

    bp_monitor #(
        .addr_width (addr_width)
    ) u_monitor (
        .clk          (clk),
        .check_en     (check_en),
        .done         (done),
        .test_id      (test_id),
        .exp_pc_if    (exp_pc_if),
        .exp_pred_pc  (exp_pred_pc),
        .pc_if        (pc_if),
        .pred_pc      (pred_pc),
        .check_count  (check_count),
        .error_count  (error_count),
        .tests_run    (tests_run),
        .tests_failed (tests_failed)
    );

    // drives one line for one cycle with advance held low when idle
    task automatic drive_line(input int n, input logic idle);
        int base;
        base        = n * n_cols;
        test_id     = int'(stim[base]);
        advance     = stim[base+1][0] && !idle;
        kind_ex     = bp_pkg::br_kind_e'(stim[base+2][1:0]);
        pc_ex       = stim[base+3][addr_width-1:0];
        target_ex   = stim[base+4][addr_width-1:0];
        mis_pdc     = stim[base+5][0];
        exp_pc_if   = stim[base+6][addr_width-1:0];
        exp_pred_pc = stim[base+7][addr_width-1:0];
        check_en    = 1'b1;
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: stimulus did not finish within %0d cycles", max_cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int gap;
        void'($urandom(32));
        rstn        = 1'b0;
        advance     = 1'b0;
        kind_ex     = bp_pkg::br_none;
        pc_ex       = '0;
        target_ex   = '0;
        mis_pdc     = 1'b0;
        check_en    = 1'b0;
        done        = 1'b0;
        test_id     = 0;
        exp_pc_if   = '0;
        exp_pred_pc = '0;
        $readmemh("bench/bp_stimulus.txt", stim);
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (int n = 0; n < n_lines; n++) begin
            gap = $urandom_range(max_gap, 0);
            repeat (gap) drive_line(n, 1'b1);
            drive_line(n, 1'b0);
        end
        check_en = 1'b0;
        advance  = 1'b0;
        mis_pdc  = 1'b0;
        kind_ex  = bp_pkg::br_none;
        done     = 1'b1;  // monitor closes the last test
        repeat (2) @(posedge clk);
        #1;
        $display("checks %0d, errors %0d, assertion failures %0d, tests passed %0d of %0d",
                 check_count, error_count, UUT.u_chk.fail_count, tests_run - tests_failed,
                 n_tests);
        if (error_count == 0 && UUT.u_chk.fail_count == 0 && tests_run == n_tests &&
            tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: bench/bp_stimulus.txt
// test advance kind_ex pc_ex target_ex mis_pdc exp_pc_if exp_pred_pc (hex)
// kind_ex: 0 none, 1 jump, 2 call, 3 ret
1 1 0 000 000 0 100 101
1 1 0 000 000 0 101 102
1 0 0 000 000 0 102 103
1 1 0 000 000 0 102 103
2 1 1 105 200 0 103 104
2 1 0 000 000 0 104 105
2 1 0 000 000 0 105 200
2 1 0 000 115 1 200 201
2 1 0 000 000 0 115 116
3 1 2 120 300 0 116 117
3 1 3 305 121 0 117 118
3 1 0 000 305 1 118 119
3 1 0 000 000 0 305 121
3 1 0 000 000 0 121 122
4 1 2 13a 400 0 122 123
4 1 2 14c 500 0 123 124
4 1 0 000 305 1 124 125
4 1 0 000 305 1 305 14d
4 1 0 000 305 1 305 13b
4 1 0 000 305 1 305 000
4 1 2 15e 600 0 305 15f
4 1 0 000 000 0 15f 160
5 1 2 171 700 0 160 161
5 1 2 182 800 0 161 162
5 1 3 390 172 1 162 163
5 1 0 000 305 1 172 173
5 1 0 000 000 0 305 15f
5 1 2 1a4 900 0 15f 160
5 1 3 390 305 1 160 161
5 1 0 000 000 0 305 1a5
5 1 2 1b6 a00 0 1a5 1a6
5 1 2 1c7 b00 0 1a6 1a7
5 1 2 1d8 c00 0 1a7 1a8
5 1 0 000 305 1 1a8 1a9
5 1 3 390 305 1 305 1d9
5 1 0 000 000 0 305 000
6 0 2 1e9 d00 1 000 001
6 0 3 390 305 1 000 001
6 1 0 000 1e9 1 000 001
6 1 0 000 000 0 1e9 1ea

// File: sources.f
src/bp_pkg.sv
src/btb.sv
src/ras.sv
src/pc_gen.sv
src/bp_top.sv
bench/bp_checker.sv
bench/bp_monitor.sv
bench/bp_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module bp_tb -f sources.f -o bp_sim || exit 1
out=$(./obj_dir/bp_sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "Test OK" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
